/* Bender.yml */
package:
  name: periph_subsys

sources:
  - files:
      - rtl/periph_pkg.sv
      - rtl/uart_core.sv
      - rtl/spi_master.sv
      - rtl/periph_reg_mux.sv
      - rtl/periph_subsys_top.sv
  - target: test
    files:
      - testbench/tb_periph_subsys.sv

/* all.f */
rtl/periph_pkg.sv
rtl/uart_core.sv
rtl/spi_master.sv
rtl/periph_reg_mux.sv
rtl/periph_subsys_top.sv
testbench/tb_periph_subsys.sv

/* rtl/periph_pkg.sv */
// Peripheral subsystem bus types, block select codes and register indices
`default_nettype none

package periph_pkg;

   ////////////////////////////////
   // Register bus
   ////////////////////////////////
   typedef struct packed {
      logic        cs;     // Level strobe, held until ack
      logic        wr;     // High for write
      logic [7:0]  addr;   // Block in 7:6, register in 5:2
      logic [31:0] wdata;
      logic [3:0]  be;     // Byte enables
   } reg_req_t;

   typedef struct packed {
      logic [31:0] rdata;  // Valid in the ack cycle
      logic        ack;    // One cycle pulse
   } reg_rsp_t;

   // Block select on addr[7:6]
   typedef enum logic [1:0] {
      SEL_UART = 2'd0,
      SEL_SPI  = 2'd1,
      SEL_IRQ  = 2'd2,
      SEL_NONE = 2'd3      // Unmapped hole
   } periph_sel_e;

   ////////////////////////////////
   // Register indices
   ////////////////////////////////
   localparam logic [3:0] UART_CTRL   = 4'd0;  // Bit 0 tx enable, bit 1 rx enable
   localparam logic [3:0] UART_BAUD   = 4'd1;  // Clocks per bit
   localparam logic [3:0] UART_TXDATA = 4'd2;
   localparam logic [3:0] UART_RXDATA = 4'd3;
   localparam logic [3:0] UART_STATUS = 4'd4;  // Busy, rx valid, overrun

   localparam logic [3:0] SPI_DIV     = 4'd0;  // Half period in clocks
   localparam logic [3:0] SPI_TXDATA  = 4'd1;
   localparam logic [3:0] SPI_RXDATA  = 4'd2;
   localparam logic [3:0] SPI_STATUS  = 4'd3;  // Bit 0 busy

   localparam logic [3:0] IRQ_STATUS  = 4'd0;  // Write 1 to clear
   localparam logic [3:0] IRQ_ENABLE  = 4'd1;

endpackage

`default_nettype wire

/* rtl/periph_reg_mux.sv */
// Address decode, response mux and interrupt combiner for the peripheral bus
`timescale 1ns/1ps
`default_nettype none

module periph_reg_mux (
   input  wire logic                 app_clk,
   input  wire logic                 arst_n_i,
   input  wire periph_pkg::reg_req_t req_i,
   input  wire periph_pkg::reg_rsp_t uart_rsp_i,
   input  wire periph_pkg::reg_rsp_t spi_rsp_i,
   input  wire logic                 uart_evt_i,
   input  wire logic                 spi_evt_i,
   output periph_pkg::reg_req_t      uart_req_o,
   output periph_pkg::reg_req_t      spi_req_o,
   output periph_pkg::reg_rsp_t      rsp_o,
   output logic                      irq_o
);
   import periph_pkg::*;

   periph_sel_e sel;
   logic [3:0]  idx;
   logic        loc_cs;                  // IRQ block or unmapped hole
   logic        loc_acc;
   logic        irq_wr;
   logic        loc_ack_q;
   logic [31:0] loc_rdata_q;
   logic [1:0]  evt;                     // Bit 0 uart rx, bit 1 spi done
   logic [1:0]  irq_status_q;
   logic [1:0]  irq_enable_q;
   logic        irq_q;

   assign sel     = periph_sel_e'(req_i.addr[7:6]);
   assign idx     = req_i.addr[5:2];
   assign evt     = {spi_evt_i, uart_evt_i};
   assign loc_cs  = req_i.cs & ((sel == SEL_IRQ) | (sel == SEL_NONE));
   assign loc_acc = loc_cs & ~loc_ack_q;
   assign irq_wr  = loc_acc & req_i.wr & (|req_i.be) & (sel == SEL_IRQ);
   assign irq_o   = irq_q;

   ////////////////////////////////
   // Strobe steering
   ////////////////////////////////
   always_comb begin
      uart_req_o    = req_i;
      spi_req_o     = req_i;
      uart_req_o.cs = req_i.cs & (sel == SEL_UART);  // Only one block sees cs
      spi_req_o.cs  = req_i.cs & (sel == SEL_SPI);
   end

   // Response follows the held address
   always_comb begin
      case (sel)
         SEL_UART: rsp_o = uart_rsp_i;
         SEL_SPI:  rsp_o = spi_rsp_i;
         default:  rsp_o = '{rdata: loc_rdata_q, ack: loc_ack_q};
      endcase
   end

   ////////////////////////////////
   // Interrupt registers
   ////////////////////////////////
   always_ff @(posedge app_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         loc_ack_q    <= 1'b0;
         loc_rdata_q  <= '0;
         irq_status_q <= '0;
         irq_enable_q <= '0;
         irq_q        <= 1'b0;
      end else begin
         loc_ack_q <= loc_acc;
         irq_q     <= |(irq_status_q & irq_enable_q);  // One cycle behind status
         // Sticky bits, a new event beats the clear
         if (irq_wr && (idx == IRQ_STATUS)) begin
            irq_status_q <= (irq_status_q & ~req_i.wdata[1:0]) | evt;
         end else begin
            irq_status_q <= irq_status_q | evt;
         end
         if (irq_wr && (idx == IRQ_ENABLE)) irq_enable_q <= req_i.wdata[1:0];
         if (loc_acc && !req_i.wr) begin
            if (sel == SEL_NONE) begin
               loc_rdata_q <= '0;         // Hole reads zero
            end else begin
               case (idx)
                  IRQ_STATUS: loc_rdata_q <= 32'(irq_status_q);
                  IRQ_ENABLE: loc_rdata_q <= 32'(irq_enable_q);
                  default:    loc_rdata_q <= '0;
               endcase
            end
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/periph_subsys_top.sv */
// Peripheral subsystem top with UART, SPI master and bus combiner
`timescale 1ns/1ps
`default_nettype none

module periph_subsys_top #(
   parameter int BAUD_W    = 16,         // UART divisor width
   parameter int SPI_DIV_W = 8           // SPI divider width
) (
   input  wire logic                 app_clk,
   input  wire logic                 arst_n_i,
   input  wire periph_pkg::reg_req_t reg_req_i,
   input  wire logic                 uart_rxd_i,
   input  wire logic                 spi_si_i,
   output periph_pkg::reg_rsp_t      reg_rsp_o,
   output logic                      uart_txd_o,
   output logic                      spi_sck_o,
   output logic                      spi_so_o,
   output logic                      spi_ssn_o,
   output logic                      irq_o
);
   import periph_pkg::*;

   reg_req_t uart_req;                   // Steered copies
   reg_req_t spi_req;
   reg_rsp_t uart_rsp;
   reg_rsp_t spi_rsp;
   logic     uart_evt;                   // Rx byte in
   logic     spi_evt;                    // Transfer done

   periph_reg_mux u_reg_mux (
      .app_clk    (app_clk   ),
      .arst_n_i   (arst_n_i  ),
      .req_i      (reg_req_i ),
      .uart_rsp_i (uart_rsp  ),
      .spi_rsp_i  (spi_rsp   ),
      .uart_evt_i (uart_evt  ),
      .spi_evt_i  (spi_evt   ),
      .uart_req_o (uart_req  ),
      .spi_req_o  (spi_req   ),
      .rsp_o      (reg_rsp_o ),
      .irq_o      (irq_o     )
   );

   uart_core #(
      .BAUD_W (BAUD_W)
   ) u_uart_core (
      .app_clk    (app_clk   ),
      .arst_n_i   (arst_n_i  ),
      .req_i      (uart_req  ),
      .uart_rxd_i (uart_rxd_i),
      .rsp_o      (uart_rsp  ),
      .uart_txd_o (uart_txd_o),
      .rx_evt_o   (uart_evt  )
   );

   spi_master #(
      .SPI_DIV_W (SPI_DIV_W)
   ) u_spi_master (
      .app_clk    (app_clk   ),
      .arst_n_i   (arst_n_i  ),
      .req_i      (spi_req   ),
      .spi_si_i   (spi_si_i  ),
      .rsp_o      (spi_rsp   ),
      .spi_sck_o  (spi_sck_o ),
      .spi_so_o   (spi_so_o  ),
      .spi_ssn_o  (spi_ssn_o ),
      .done_evt_o (spi_evt   )
   );

endmodule

`default_nettype wire

/* rtl/spi_master.sv */
// SPI master for mode 0 byte exchanges with divider and register file
`timescale 1ns/1ps
`default_nettype none

module spi_master #(
   parameter int SPI_DIV_W = 8           // Divider width
) (
   input  wire logic                 app_clk,
   input  wire logic                 arst_n_i,
   input  wire periph_pkg::reg_req_t req_i,
   input  wire logic                 spi_si_i,
   output periph_pkg::reg_rsp_t      rsp_o,
   output logic                      spi_sck_o,
   output logic                      spi_so_o,
   output logic                      spi_ssn_o,
   output logic                      done_evt_o
);
   import periph_pkg::*;

   logic                 ack_q;
   logic [31:0]          rdata_q;
   logic [3:0]           idx;
   logic                 acc;            // First cycle of a strobe
   logic                 wr_en;
   logic                 rd_en;
   logic                 start;

   logic [SPI_DIV_W-1:0] div_q;
   logic [SPI_DIV_W-1:0] cnt_q;          // Half period countdown
   logic [7:0]           txdata_q;
   logic [7:0]           rxdata_q;
   logic [7:0]           tx_shift_q;
   logic [7:0]           rx_shift_q;
   logic [3:0]           edge_q;         // Sck edges so far
   logic                 busy_q;
   logic                 sck_q;
   logic                 done_q;

   assign idx   = req_i.addr[5:2];
   assign acc   = req_i.cs & ~ack_q;
   assign wr_en = acc & req_i.wr & (|req_i.be);
   assign rd_en = acc & ~req_i.wr;
   assign start = wr_en & (idx == SPI_TXDATA) & ~busy_q;

   assign rsp_o      = '{rdata: rdata_q, ack: ack_q};
   assign spi_sck_o  = sck_q;
   assign spi_so_o   = tx_shift_q[7];    // MSB first
   assign spi_ssn_o  = ~busy_q;          // Low only during a transfer
   assign done_evt_o = done_q;

   ////////////////////////////////
   // Register access
   ////////////////////////////////
   always_ff @(posedge app_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q   <= 1'b0;
         rdata_q <= '0;
         div_q   <= SPI_DIV_W'(1);       // Smallest legal divider
      end else begin
         ack_q <= acc;
         if (rd_en) begin
            case (idx)
               SPI_DIV:    rdata_q <= 32'(div_q);
               SPI_TXDATA: rdata_q <= 32'(txdata_q);
               SPI_RXDATA: rdata_q <= 32'(rxdata_q);
               SPI_STATUS: rdata_q <= 32'(busy_q);
               default:    rdata_q <= '0;
            endcase
         end
         if (wr_en && (idx == SPI_DIV)) div_q <= req_i.wdata[SPI_DIV_W-1:0];
      end
   end

   ////////////////////////////////
   // Shifter
   ////////////////////////////////
   always_ff @(posedge app_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         busy_q     <= 1'b0;
         sck_q      <= 1'b0;
         done_q     <= 1'b0;
         cnt_q      <= '0;
         edge_q     <= '0;
         txdata_q   <= '0;
         rxdata_q   <= '0;
         tx_shift_q <= '0;
         rx_shift_q <= '0;
      end else begin
         done_q <= 1'b0;
         if (start) begin
            busy_q     <= 1'b1;
            txdata_q   <= req_i.wdata[7:0];
            tx_shift_q <= req_i.wdata[7:0];  // First bit out before first rise
            cnt_q      <= div_q;
            edge_q     <= '0;
         end else if (busy_q) begin
            if (cnt_q != '0) begin
               cnt_q <= cnt_q - 1'b1;
            end else begin
               cnt_q  <= div_q;
               sck_q  <= ~sck_q;
               edge_q <= edge_q + 1'b1;
               if (!sck_q) begin
                  rx_shift_q <= {rx_shift_q[6:0], spi_si_i};  // Rising edge samples
               end else begin
                  tx_shift_q <= {tx_shift_q[6:0], 1'b0};      // Falling edge shifts
               end
               // Last falling edge ends the byte
               if (edge_q == 4'd15) begin
                  busy_q   <= 1'b0;
                  rxdata_q <= rx_shift_q;
                  done_q   <= 1'b1;
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/uart_core.sv */
// UART controller with 8N1 transmitter, receiver and register file
`timescale 1ns/1ps
`default_nettype none

module uart_core #(
   parameter int BAUD_W = 16             // Divisor width
) (
   input  wire logic                 app_clk,
   input  wire logic                 arst_n_i,
   input  wire periph_pkg::reg_req_t req_i,
   input  wire logic                 uart_rxd_i,
   output periph_pkg::reg_rsp_t      rsp_o,
   output logic                      uart_txd_o,
   output logic                      rx_evt_o
);
   import periph_pkg::*;

   // Bus side
   logic              ack_q;
   logic [31:0]       rdata_q;
   logic [3:0]        idx;
   logic              acc;               // First cycle of a strobe
   logic              wr_en;
   logic              rd_en;

   // Register file
   logic [1:0]        ctrl_q;
   logic [BAUD_W-1:0] baud_q;
   logic [7:0]        txdata_q;
   logic [7:0]        rxdata_q;
   logic              rx_valid_q;
   logic              overrun_q;

   // Transmitter
   logic              tx_start;
   logic              tx_busy_q;
   logic [9:0]        tx_shift_q;        // Stop, data, start
   logic [3:0]        tx_bit_q;
   logic [BAUD_W-1:0] tx_cnt_q;

   // Receiver
   logic [2:0]        rxd_sync_q;        // Two sync stages plus edge history
   logic              rx_busy_q;
   logic [3:0]        rx_bit_q;
   logic [BAUD_W-1:0] rx_cnt_q;
   logic [7:0]        rx_shift_q;
   logic              rx_done;
   logic              rx_evt_q;

   assign idx      = req_i.addr[5:2];
   assign acc      = req_i.cs & ~ack_q;
   assign wr_en    = acc & req_i.wr & (|req_i.be);
   assign rd_en    = acc & ~req_i.wr;
   assign tx_start = wr_en & (idx == UART_TXDATA) & ctrl_q[0] & ~tx_busy_q;
   // Middle of a good stop bit
   assign rx_done  = rx_busy_q & (rx_cnt_q == '0) & (rx_bit_q == 4'd9) & rxd_sync_q[1];

   assign rsp_o      = '{rdata: rdata_q, ack: ack_q};
   assign uart_txd_o = tx_busy_q ? tx_shift_q[0] : 1'b1;  // Idle line high
   assign rx_evt_o   = rx_evt_q;

   ////////////////////////////////
   // Register file
   ////////////////////////////////
   always_ff @(posedge app_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q      <= 1'b0;
         rdata_q    <= '0;
         ctrl_q     <= '0;
         baud_q     <= BAUD_W'(4);       // Smallest legal divisor
         txdata_q   <= '0;
         rxdata_q   <= '0;
         rx_valid_q <= 1'b0;
         overrun_q  <= 1'b0;
      end else begin
         ack_q <= acc;
         if (rd_en) begin
            case (idx)
               UART_CTRL:   rdata_q <= 32'(ctrl_q);
               UART_BAUD:   rdata_q <= 32'(baud_q);
               UART_TXDATA: rdata_q <= 32'(txdata_q);
               UART_RXDATA: rdata_q <= 32'(rxdata_q);
               UART_STATUS: rdata_q <= 32'({overrun_q, rx_valid_q, tx_busy_q});
               default:     rdata_q <= '0;
            endcase
         end
         if (wr_en) begin
            case (idx)
               UART_CTRL:   ctrl_q <= req_i.wdata[1:0];
               UART_BAUD:   baud_q <= req_i.wdata[BAUD_W-1:0];
               UART_STATUS: if (req_i.wdata[2]) overrun_q <= 1'b0;  // W1C
               default:     ;
            endcase
         end
         if (tx_start) txdata_q <= req_i.wdata[7:0];  // Busy writes dropped
         if (rd_en && (idx == UART_RXDATA)) rx_valid_q <= 1'b0;
         // New frame wins over a read in the same cycle
         if (rx_done) begin
            rxdata_q   <= rx_shift_q;
            rx_valid_q <= 1'b1;
            if (rx_valid_q) overrun_q <= 1'b1;  // Previous byte never read
         end
      end
   end

   ////////////////////////////////
   // Transmitter
   ////////////////////////////////
   always_ff @(posedge app_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         tx_busy_q  <= 1'b0;
         tx_shift_q <= '1;
         tx_bit_q   <= '0;
         tx_cnt_q   <= '0;
      end else if (tx_start) begin
         tx_busy_q  <= 1'b1;
         tx_shift_q <= {1'b1, req_i.wdata[7:0], 1'b0};
         tx_bit_q   <= '0;
         tx_cnt_q   <= baud_q - 1'b1;
      end else if (tx_busy_q) begin
         if (tx_cnt_q != '0) begin
            tx_cnt_q <= tx_cnt_q - 1'b1;
         end else if (tx_bit_q == 4'd9) begin
            tx_busy_q <= 1'b0;           // Stop bit done
         end else begin
            tx_shift_q <= {1'b1, tx_shift_q[9:1]};  // LSB first
            tx_bit_q   <= tx_bit_q + 1'b1;
            tx_cnt_q   <= baud_q - 1'b1;
         end
      end
   end

   ////////////////////////////////
   // Receiver
   ////////////////////////////////
   always_ff @(posedge app_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rxd_sync_q <= '1;
         rx_busy_q  <= 1'b0;
         rx_bit_q   <= '0;
         rx_cnt_q   <= '0;
         rx_shift_q <= '0;
         rx_evt_q   <= 1'b0;
      end else begin
         rxd_sync_q <= {rxd_sync_q[1:0], uart_rxd_i};
         rx_evt_q   <= rx_done;
         if (!rx_busy_q) begin
            // Falling edge opens a frame
            if (ctrl_q[1] && rxd_sync_q[2] && !rxd_sync_q[1]) begin
               rx_busy_q <= 1'b1;
               rx_bit_q  <= '0;
               rx_cnt_q  <= baud_q >> 1;  // Half bit to mid start
            end
         end else if (rx_cnt_q != '0) begin
            rx_cnt_q <= rx_cnt_q - 1'b1;
         end else begin
            rx_cnt_q <= baud_q - 1'b1;
            rx_bit_q <= rx_bit_q + 1'b1;
            if (rx_bit_q == 4'd0) begin
               if (rxd_sync_q[1]) rx_busy_q <= 1'b0;  // Glitch, not a start bit
            end else if (rx_bit_q == 4'd9) begin
               rx_busy_q <= 1'b0;
            end else begin
               rx_shift_q <= {rxd_sync_q[1], rx_shift_q[7:1]};
            end
         end
      end
   end

endmodule

`default_nettype wire

/* testbench/tb_periph_subsys.sv */
// Random self-checking testbench for the peripheral subsystem with pin loopbacks
`timescale 1ns/1ps
`default_nettype none

module tb_periph_subsys;
   import periph_pkg::*;

   localparam int CLK_PERIOD = 4;
   localparam int MAX_BAUD   = 19;                  // Largest random UART divisor
   localparam int MAX_DIV    = 8;                   // Largest random SPI divider
   localparam int WD_CYCLES  = 20 * (10 * MAX_BAUD + 16 * (MAX_DIV + 1)) + 1000;

   typedef struct packed {
      logic txd;
      logic sck;
      logic ssn;
      logic irq;
   } pins_t;

   logic        app_clk;
   logic        arst_n;
   reg_req_t    reg_req;
   reg_rsp_t    reg_rsp;
   logic        uart_txd;
   logic        spi_sck;
   logic        spi_so;
   logic        spi_ssn;
   logic        irq;
   pins_t       pins;
   logic [31:0] lcg_state;
   int          baud_m;                             // Register model
   int          div_m;
   logic [1:0]  status_m;                           // Bit 0 uart rx, bit 1 spi done
   logic [1:0]  en_m;
   int          ssn_low_cycles;

   assign pins = {uart_txd, spi_sck, spi_ssn, irq};

   periph_subsys_top #(
      .BAUD_W    (16),
      .SPI_DIV_W (8)
   ) UUT (
      .app_clk    (app_clk ),
      .arst_n_i   (arst_n  ),
      .reg_req_i  (reg_req ),
      .uart_rxd_i (uart_txd),                       // Loopback
      .spi_si_i   (spi_so  ),                       // Loopback
      .reg_rsp_o  (reg_rsp ),
      .uart_txd_o (uart_txd),
      .spi_sck_o  (spi_sck ),
      .spi_so_o   (spi_so  ),
      .spi_ssn_o  (spi_ssn ),
      .irq_o      (irq     )
   );

   always #(CLK_PERIOD / 2) app_clk = ~app_clk;

   // Slave select low time per transfer
   always @(negedge app_clk) begin
      if (!spi_ssn) ssn_low_cycles = ssn_low_cycles + 1;
   end

   ////////////////////////////////
   // Helpers
   ////////////////////////////////
   task automatic fail_stop(input string msg);
      $display("%s", msg);
      $display("TEST RESULT: FAIL");
      $fatal(1);
   endtask

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // LCG step
      return lcg_state;
   endfunction

   function automatic logic [7:0] reg_addr(input periph_sel_e sel, input logic [3:0] idx);
      return {sel, idx, 2'b00};
   endfunction

   function automatic pins_t idle_pins();
      pins_t p;
      p.txd = 1'b1;
      p.sck = 1'b0;
      p.ssn = 1'b1;
      p.irq = |(status_m & en_m);                   // Status AND mask
      return p;
   endfunction

   task automatic check_rsp(input reg_rsp_t got, input reg_rsp_t exp, input string what);
      if (got !== exp) begin
         fail_stop($sformatf("Error at %0d ns: %s read 0x%08h ack %0b, expected 0x%08h ack %0b",
                             $time, what, got.rdata, got.ack, exp.rdata, exp.ack));
      end
   endtask

   task automatic check_pins(input pins_t got, input pins_t exp, input string what);
      if (got !== exp) begin
         fail_stop($sformatf("Error at %0d ns: %s pins txd,sck,ssn,irq %b, expected %b",
                             $time, what, got, exp));
      end
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      if (got != exp) begin
         fail_stop($sformatf("Error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp));
      end
   endtask

   ////////////////////////////////
   // Bus tasks
   ////////////////////////////////
   task automatic bus_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                             output reg_rsp_t rsp);
      reg_req_t req_next;
      int       waited;
      req_next.cs    = 1'b1;
      req_next.wr    = wr;
      req_next.addr  = addr;
      req_next.wdata = wdata;
      req_next.be    = 4'hf;
      waited         = 0;
      @(posedge app_clk);
      reg_req <= req_next;                          // Held until ack
      do begin
         @(negedge app_clk);
         waited++;
      end while (!reg_rsp.ack && waited < 8);
      if (!reg_rsp.ack) begin
         fail_stop($sformatf("No bus ack for address 0x%02h", addr));
      end else if (waited != 2) begin
         fail_stop($sformatf("Bus ack for address 0x%02h came %0d cycles after cs, not 1",
                             addr, waited - 1));
      end
      rsp = reg_rsp;
      @(posedge app_clk);
      reg_req <= '0;
   endtask

   task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
      reg_rsp_t rsp;
      bus_access(1'b1, addr, data, rsp);
   endtask

   task automatic bus_read(input logic [7:0] addr, output reg_rsp_t rsp);
      bus_access(1'b0, addr, '0, rsp);
   endtask

   task automatic expect_read(input logic [7:0] addr, input logic [31:0] data, input string what);
      reg_rsp_t got;
      reg_rsp_t exp;
      exp.rdata = data;
      exp.ack   = 1'b1;
      bus_read(addr, got);
      check_rsp(got, exp, what);
   endtask

   ////////////////////////////////
   // Transfers
   ////////////////////////////////
   task automatic uart_transfer(input logic [7:0] data);
      reg_rsp_t rsp;
      bus_write(reg_addr(SEL_UART, UART_TXDATA), 32'(data));
      do begin
         bus_read(reg_addr(SEL_UART, UART_STATUS), rsp);
      end while (rsp.rdata[1:0] != 2'b10);          // Rx valid and tx idle
      status_m[0] = 1'b1;
      expect_read(reg_addr(SEL_UART, UART_RXDATA), 32'(data), "UART RXDATA");
      expect_read(reg_addr(SEL_UART, UART_STATUS), 32'h0, "UART STATUS after read");
      @(negedge app_clk);
      check_pins(pins, idle_pins(), "after UART frame");
   endtask

   task automatic spi_transfer(input logic [7:0] data);
      reg_rsp_t rsp;
      ssn_low_cycles = 0;
      bus_write(reg_addr(SEL_SPI, SPI_TXDATA), 32'(data));
      do begin
         bus_read(reg_addr(SEL_SPI, SPI_STATUS), rsp);
      end while (rsp.rdata[0]);
      status_m[1] = 1'b1;
      expect_read(reg_addr(SEL_SPI, SPI_RXDATA), 32'(data), "SPI RXDATA");
      check_count(ssn_low_cycles, 16 * (div_m + 1), "SPI ssn low cycles");
      @(negedge app_clk);
      check_pins(pins, idle_pins(), "after SPI transfer");
   endtask

   ////////////////////////////////
   // Test sequence
   ////////////////////////////////
   initial begin : main
      logic [31:0] r;
      logic [1:0]  ctrl_m;
      app_clk   = 1'b0;
      arst_n    = 1'b0;
      reg_req   = '0;
      lcg_state = 32'h825d;
      baud_m    = 4;
      div_m     = 1;
      status_m  = '0;
      en_m      = '0;
      repeat (10) @(posedge app_clk);
      arst_n <= 1'b1;

      // Reset values
      @(negedge app_clk);
      check_pins(pins, idle_pins(), "after reset");
      expect_read(reg_addr(SEL_UART, UART_CTRL), 32'h0, "UART CTRL reset");
      expect_read(reg_addr(SEL_UART, UART_BAUD), 32'd4, "UART BAUD reset");
      expect_read(reg_addr(SEL_UART, UART_TXDATA), 32'h0, "UART TXDATA reset");
      expect_read(reg_addr(SEL_UART, UART_RXDATA), 32'h0, "UART RXDATA reset");
      expect_read(reg_addr(SEL_UART, UART_STATUS), 32'h0, "UART STATUS reset");
      expect_read(reg_addr(SEL_SPI, SPI_DIV), 32'd1, "SPI DIV reset");
      expect_read(reg_addr(SEL_SPI, SPI_TXDATA), 32'h0, "SPI TXDATA reset");
      expect_read(reg_addr(SEL_SPI, SPI_RXDATA), 32'h0, "SPI RXDATA reset");
      expect_read(reg_addr(SEL_SPI, SPI_STATUS), 32'h0, "SPI STATUS reset");
      expect_read(reg_addr(SEL_IRQ, IRQ_STATUS), 32'h0, "IRQ STATUS reset");
      expect_read(reg_addr(SEL_IRQ, IRQ_ENABLE), 32'h0, "IRQ ENABLE reset");

      // UART loopback
      bus_write(reg_addr(SEL_UART, UART_CTRL), 32'h3);  // TX and RX on
      repeat (4) begin
         r      = next_rand();
         baud_m = 4 + r[3:0];                        // 4 to 19
         bus_write(reg_addr(SEL_UART, UART_BAUD), 32'(baud_m));
         uart_transfer(r[31:24]);
      end

      // SPI loopback
      repeat (4) begin
         r     = next_rand();
         div_m = 1 + r[2:0];                         // 1 to 8
         bus_write(reg_addr(SEL_SPI, SPI_DIV), 32'(div_m));
         spi_transfer(r[31:24]);
      end

      // Interrupts
      bus_write(reg_addr(SEL_IRQ, IRQ_STATUS), 32'h3);
      status_m = '0;
      expect_read(reg_addr(SEL_IRQ, IRQ_STATUS), 32'h0, "IRQ STATUS after clear");
      r    = next_rand();
      en_m = r[9:8];
      bus_write(reg_addr(SEL_IRQ, IRQ_ENABLE), 32'(en_m));
      expect_read(reg_addr(SEL_IRQ, IRQ_ENABLE), 32'(en_m), "IRQ ENABLE");
      uart_transfer(r[23:16]);
      spi_transfer(r[31:24]);
      expect_read(reg_addr(SEL_IRQ, IRQ_STATUS), 32'(status_m), "IRQ STATUS after events");
      bus_write(reg_addr(SEL_IRQ, IRQ_STATUS), 32'h3);  // Write 1 clears
      status_m = '0;
      expect_read(reg_addr(SEL_IRQ, IRQ_STATUS), 32'h0, "IRQ STATUS after W1C");
      @(negedge app_clk);
      check_pins(pins, idle_pins(), "after IRQ clear");

      // Decode isolation
      // A leaked write lands on the same index in the other block
      r      = next_rand();
      div_m  = 1 + r[2:0];
      ctrl_m = ~div_m[1:0];                          // Never equal to leaked divider bits
      bus_write(reg_addr(SEL_UART, UART_CTRL), 32'(ctrl_m));
      bus_write(reg_addr(SEL_SPI, SPI_DIV), 32'(div_m));
      expect_read(reg_addr(SEL_UART, UART_CTRL), 32'(ctrl_m), "UART CTRL after SPI write");
      expect_read(reg_addr(SEL_UART, UART_BAUD), 32'(baud_m), "UART BAUD after SPI write");
      baud_m = 4 + r[7:4];
      bus_write(reg_addr(SEL_UART, UART_BAUD), 32'(baud_m));
      expect_read(reg_addr(SEL_SPI, SPI_DIV), 32'(div_m), "SPI DIV after UART write");
      // Leaked TXDATA write would leave the shifter busy
      expect_read(reg_addr(SEL_SPI, SPI_STATUS), 32'h0, "SPI STATUS after UART write");
      expect_read(reg_addr(SEL_NONE, r[11:8]), 32'h0, "Unmapped region");

      $display("TEST RESULT: PASS");
      $finish;
   end

   // Watchdog
   initial begin
      #(WD_CYCLES * CLK_PERIOD);
      fail_stop($sformatf("Simulation did not finish within %0d clock cycles", WD_CYCLES));
   end

endmodule

`default_nettype wire
